// ==== src/erx_pkg.sv ====
package erx_pkg;

   typedef logic [31:0] addr_t;                  // Mesh address
   typedef logic [31:0] data_t;                  // Mesh data word
   typedef logic [11:0] chip_id_t;               // Chip ID, addr[31:20]
   typedef logic [3:0]  reg_index_t;             // Register index, addr[5:2]

   // Link packet, 104 bits, write flag on top
   typedef struct packed {
      logic       write;                         // Write or read response
      logic [1:0] datamode;                      // Passed through untouched
      logic [4:0] ctrlmode;                      // Passed through untouched
      addr_t      dstaddr;
      data_t      data;                          // Write or response data
      addr_t      srcaddr;                       // Return address of a read
   } emesh_packet_t;

   // Static remap setup
   typedef struct packed {
      logic     mode;                            // 1 = static remap on
      chip_id_t sel;                             // Bits to replace
      chip_id_t pattern;                         // Replacement bits
   } remap_cfg_t;

   // Region codes in addr[19:16]
   localparam logic [3:0] reg_region_c = 4'hF;   // Local register space
   localparam logic [3:0] rr_region_c  = 4'hE;   // Read responses to us

   // Register map
   localparam reg_index_t reg_remap_mode_c    = 4'd0;
   localparam reg_index_t reg_remap_sel_c     = 4'd1;
   localparam reg_index_t reg_remap_pattern_c = 4'd2;
   localparam reg_index_t reg_idelay_lo_c     = 4'd3;
   localparam reg_index_t reg_idelay_hi_c     = 4'd4;   // Also loads taps
   localparam reg_index_t reg_mailbox_c       = 4'd5;   // Push remote, pop cfg read

endpackage

// ==== src/erx_protocol.sv ====
`timescale 1ns/1ns
module erx_protocol #(
   parameter erx_pkg::chip_id_t ID = 12'h999
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   rx_access,
   input  erx_pkg::emesh_packet_t rx_packet,
   input  logic                   stall,
   output logic                   dec_access,
   output logic                   dec_rr,
   output erx_pkg::emesh_packet_t dec_packet
);
   import erx_pkg::*;

   logic is_rr;                                           // Response to this chip

   // Read response when addressed to our ID in the rr region
   assign is_rr = (rx_packet.dstaddr[31:20] == ID) &&
                  (rx_packet.dstaddr[19:16] == rr_region_c);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dec_access <= 1'b0;
         dec_rr     <= 1'b0;
      end else if (!stall) begin                          // Whole pipe freezes
         dec_access <= rx_access;
         dec_rr     <= rx_access && is_rr;
      end
   end

   // Payload only
   always_ff @(posedge clk) begin
      if (!stall) begin
         dec_packet <= rx_packet;
      end
   end

endmodule

// ==== src/erx_remap.sv ====
`timescale 1ns/1ns
module erx_remap (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   dec_access,
   input  logic                   dec_rr,
   input  erx_pkg::emesh_packet_t dec_packet,
   input  erx_pkg::remap_cfg_t    remap,
   input  logic                   stall,
   output logic                   exe_access,
   output logic                   exe_rr,
   output erx_pkg::emesh_packet_t exe_packet
);
   import erx_pkg::*;

   emesh_packet_t pkt_next;                               // Remapped packet

   always_comb begin
      pkt_next = dec_packet;
      if (remap.mode && !dec_rr) begin                    // Responses keep address
         pkt_next.dstaddr[31:20] = (dec_packet.dstaddr[31:20] & ~remap.sel) |
                                   (remap.pattern & remap.sel);
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         exe_access <= 1'b0;
         exe_rr     <= 1'b0;
      end else if (!stall) begin
         exe_access <= dec_access;
         exe_rr     <= dec_rr;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         exe_packet <= pkt_next;                          // Hold on stall
      end
   end

endmodule

// ==== src/erx_cfg.sv ====
`timescale 1ns/1ns
module erx_cfg #(
   parameter erx_pkg::chip_id_t ID = 12'h999
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   erx_cfg_access,
   input  erx_pkg::emesh_packet_t erx_cfg_packet,
   input  logic                   cfg_rsp_wait,
   input  erx_pkg::data_t         mb_head,
   output logic                   erx_cfg_wait,
   output erx_pkg::remap_cfg_t    remap,
   output logic [44:0]            idelay_value,
   output logic                   load_taps,
   output logic                   cfg_rsp_access,
   output erx_pkg::emesh_packet_t cfg_rsp_packet,
   output logic                   mb_pop
);
   import erx_pkg::*;

   reg_index_t  idx;                                      // Decoded register
   logic        cfg_wr;
   logic        cfg_rd;
   data_t       idelay_lo;
   logic [12:0] idelay_hi;
   data_t       rd_value;                                 // Readback mux

   assign idx    = erx_cfg_packet.dstaddr[5:2];
   assign cfg_wr = erx_cfg_access && !erx_cfg_wait && erx_cfg_packet.write &&
                   erx_cfg_packet.dstaddr[31:20] == ID &&
                   erx_cfg_packet.dstaddr[19:16] == reg_region_c;
   assign cfg_rd = erx_cfg_access && !erx_cfg_wait && !erx_cfg_packet.write &&
                   erx_cfg_packet.dstaddr[31:20] == ID &&
                   erx_cfg_packet.dstaddr[19:16] == reg_region_c;
   assign mb_pop       = cfg_rd && (idx == reg_mailbox_c); // Ignored by mailbox if empty
   assign erx_cfg_wait = cfg_rsp_access && cfg_rsp_wait;  // Pending, not granted
   assign idelay_value = {idelay_hi, idelay_lo};

   always_comb begin
      case (idx)
         reg_remap_mode_c:    rd_value = {31'd0, remap.mode};
         reg_remap_sel_c:     rd_value = {20'd0, remap.sel};
         reg_remap_pattern_c: rd_value = {20'd0, remap.pattern};
         reg_idelay_lo_c:     rd_value = idelay_lo;
         reg_idelay_hi_c:     rd_value = {19'd0, idelay_hi};
         reg_mailbox_c:       rd_value = mb_head;        // Zero when empty
         default:             rd_value = '0;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         remap          <= '0;
         idelay_lo      <= '0;
         idelay_hi      <= '0;
         load_taps      <= 1'b0;
         cfg_rsp_access <= 1'b0;
      end else begin
         load_taps <= cfg_wr && (idx == reg_idelay_hi_c); // One-cycle pulse
         if (cfg_wr && idx == reg_remap_mode_c)    remap.mode    <= erx_cfg_packet.data[0];
         if (cfg_wr && idx == reg_remap_sel_c)     remap.sel     <= erx_cfg_packet.data[11:0];
         if (cfg_wr && idx == reg_remap_pattern_c) remap.pattern <= erx_cfg_packet.data[11:0];
         if (cfg_wr && idx == reg_idelay_lo_c)     idelay_lo     <= erx_cfg_packet.data;
         if (cfg_wr && idx == reg_idelay_hi_c)     idelay_hi     <= erx_cfg_packet.data[12:0];
         if (cfg_rd) begin
            cfg_rsp_access <= 1'b1;
         end else if (!cfg_rsp_wait) begin                // Granted by arbiter
            cfg_rsp_access <= 1'b0;
         end
      end
   end

   // Response packet, addresses swapped
   always_ff @(posedge clk) begin
      if (cfg_rd) begin
         cfg_rsp_packet <= '{write: 1'b1, datamode: erx_cfg_packet.datamode,
                             ctrlmode: erx_cfg_packet.ctrlmode,
                             dstaddr: erx_cfg_packet.srcaddr, data: rd_value,
                             srcaddr: erx_cfg_packet.dstaddr};
      end
   end

endmodule

// ==== src/erx_mailbox.sv ====
`timescale 1ns/1ns
module erx_mailbox #(
   parameter erx_pkg::chip_id_t ID       = 12'h999,
   parameter int                MB_DEPTH = 4
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   exe_access,
   input  erx_pkg::emesh_packet_t exe_packet,
   input  logic                   mb_pop,
   output erx_pkg::data_t         mb_head,
   output logic                   mailbox_full,
   output logic                   mailbox_not_empty
);
   import erx_pkg::*;

   localparam int ptr_bits_c = (MB_DEPTH > 1) ? $clog2(MB_DEPTH) : 1;
   localparam int cnt_bits_c = $clog2(MB_DEPTH + 1);

   typedef logic [ptr_bits_c-1:0] ptr_t;
   typedef logic [cnt_bits_c-1:0] count_t;

   data_t  mem [MB_DEPTH];                                // Word storage
   ptr_t   wr_ptr;
   ptr_t   rd_ptr;
   count_t count;                                         // Words held
   logic   push;
   logic   pop;

   // Circular increment, depth need not be a power of two
   function automatic ptr_t ptr_inc(input ptr_t p);
      return (p == ptr_t'(MB_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign push = exe_access && exe_packet.write && !mailbox_full &&
                 exe_packet.dstaddr[31:20] == ID &&
                 exe_packet.dstaddr[19:16] == reg_region_c &&
                 exe_packet.dstaddr[5:2] == reg_mailbox_c;   // Full drops it
   assign pop               = mb_pop && mailbox_not_empty;
   assign mailbox_full      = (count == count_t'(MB_DEPTH));
   assign mailbox_not_empty = (count != '0);
   assign mb_head           = mailbox_not_empty ? mem[rd_ptr] : '0;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= ptr_inc(wr_ptr);
         if (pop)  rd_ptr <= ptr_inc(rd_ptr);
         count <= count + count_t'(push) - count_t'(pop);  // Both may happen
      end
   end

   always_ff @(posedge clk) begin
      if (push) mem[wr_ptr] <= exe_packet.data;
   end

endmodule

// ==== src/erx_arbiter.sv ====
`timescale 1ns/1ns
module erx_arbiter (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   exe_access,
   input  logic                   exe_rr,
   input  erx_pkg::emesh_packet_t exe_packet,
   input  logic                   cfg_rsp_access,
   input  erx_pkg::emesh_packet_t cfg_rsp_packet,
   input  logic                   rxwr_wait,
   input  logic                   rxrd_wait,
   input  logic                   rxrr_wait,
   output logic                   stall,
   output logic                   rx_wr_wait,
   output logic                   rx_rd_wait,
   output logic                   cfg_rsp_wait,
   output logic                   rxwr_access,
   output erx_pkg::emesh_packet_t rxwr_packet,
   output logic                   rxrd_access,
   output erx_pkg::emesh_packet_t rxrd_packet,
   output logic                   rxrr_access,
   output erx_pkg::emesh_packet_t rxrr_packet
);
   import erx_pkg::*;

   localparam int port_wr_c = 0;
   localparam int port_rd_c = 1;
   localparam int port_rr_c = 2;

   logic          link_rr;                                // Link response wins rxrr
   logic [2:0]    out_wait;
   logic [2:0]    out_load;                               // New packet per port
   logic [2:0]    out_access;
   emesh_packet_t out_next [3];
   emesh_packet_t out_packet [3];

   assign stall        = rxwr_wait | rxrd_wait | rxrr_wait;
   assign rx_wr_wait   = stall;
   assign rx_rd_wait   = stall;
   assign link_rr      = exe_access && exe_rr;
   assign cfg_rsp_wait = stall || link_rr;                // Cfg loses to link

   assign out_wait = {rxrr_wait, rxrd_wait, rxwr_wait};
   assign out_load[port_wr_c] = !stall && exe_access && !exe_rr && exe_packet.write;
   assign out_load[port_rd_c] = !stall && exe_access && !exe_rr && !exe_packet.write;
   assign out_load[port_rr_c] = !stall && (link_rr || cfg_rsp_access);
   assign out_next[port_wr_c] = exe_packet;
   assign out_next[port_rd_c] = exe_packet;
   assign out_next[port_rr_c] = link_rr ? exe_packet : cfg_rsp_packet;

   // Free port clears its strobe unless reloaded, a waiting port holds
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_access <= '0;
      end else begin
         for (int i = 0; i < 3; i++) begin
            if (!out_wait[i]) out_access[i] <= out_load[i];
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < 3; i++) begin
         if (out_load[i]) out_packet[i] <= out_next[i];   // Load implies no wait
      end
   end

   assign rxwr_access = out_access[port_wr_c];
   assign rxrd_access = out_access[port_rd_c];
   assign rxrr_access = out_access[port_rr_c];
   assign rxwr_packet = out_packet[port_wr_c];
   assign rxrd_packet = out_packet[port_rd_c];
   assign rxrr_packet = out_packet[port_rr_c];

endmodule

// ==== src/erx_core.sv ====
`timescale 1ns/1ns
module erx_core #(
   parameter erx_pkg::chip_id_t ID       = 12'h999,
   parameter int                MB_DEPTH = 4
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   rx_access,
   input  erx_pkg::emesh_packet_t rx_packet,
   input  logic                   rx_burst,            // Bursts not handled
   output logic                   rx_rd_wait,
   output logic                   rx_wr_wait,
   input  logic                   erx_cfg_access,
   input  erx_pkg::emesh_packet_t erx_cfg_packet,
   output logic                   erx_cfg_wait,
   output logic                   rxwr_access,
   output erx_pkg::emesh_packet_t rxwr_packet,
   input  logic                   rxwr_wait,
   output logic                   rxrd_access,
   output erx_pkg::emesh_packet_t rxrd_packet,
   input  logic                   rxrd_wait,
   output logic                   rxrr_access,
   output erx_pkg::emesh_packet_t rxrr_packet,
   input  logic                   rxrr_wait,
   output logic [44:0]            idelay_value,
   output logic                   load_taps,
   output logic                   mailbox_full,
   output logic                   mailbox_not_empty
);
   import erx_pkg::*;

   logic          stall;                                  // Any output port waiting
   logic          dec_access;
   logic          dec_rr;
   emesh_packet_t dec_packet;
   logic          exe_access;
   logic          exe_rr;
   emesh_packet_t exe_packet;
   logic          exe_leave;                              // Execute hands off
   remap_cfg_t    remap;
   logic          cfg_rsp_access;
   emesh_packet_t cfg_rsp_packet;
   logic          cfg_rsp_wait;
   logic          mb_pop;
   data_t         mb_head;

   assign exe_leave = exe_access && !stall;               // Push once per packet

   erx_protocol #(.ID(ID)) erx_protocol (.*);
   erx_remap erx_remap (.*);
   erx_cfg #(.ID(ID)) erx_cfg (.*);
   erx_mailbox #(.ID(ID), .MB_DEPTH(MB_DEPTH)) erx_mailbox (.exe_access(exe_leave), .*);
   erx_arbiter erx_arbiter (.*);

endmodule

// ==== tb/erx_properties.sv ====
`timescale 1ns/1ns
module erx_properties #(
   parameter erx_pkg::chip_id_t ID = 12'h999
) (
   input logic                   clk,
   input logic                   rst_n,
   input logic                   rxwr_access,
   input erx_pkg::emesh_packet_t rxwr_packet,
   input logic                   rxwr_wait,
   input logic                   rxrd_access,
   input erx_pkg::emesh_packet_t rxrd_packet,
   input logic                   rxrd_wait,
   input logic                   rxrr_access,
   input erx_pkg::emesh_packet_t rxrr_packet,
   input logic                   rxrr_wait,
   input logic                   mailbox_full,
   input logic                   mailbox_not_empty,
   input logic                   exe_leave,
   input erx_pkg::emesh_packet_t exe_packet,
   input logic                   mb_pop
);
   import erx_pkg::*;

   logic mb_push;                                         // Remote write into the mailbox

   assign mb_push = exe_leave && exe_packet.write &&
                    exe_packet.dstaddr[31:20] == ID &&
                    exe_packet.dstaddr[19:16] == reg_region_c &&
                    exe_packet.dstaddr[5:2] == reg_mailbox_c;

   // Strobes low while reset holds
   a_reset_low: assert property (@(posedge clk)
      !rst_n |-> !(rxwr_access || rxrd_access || rxrr_access)) else $error("access in reset");

   // Waiting port keeps strobe and payload
   a_wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
      rxwr_access && rxwr_wait |=> rxwr_access && $stable(rxwr_packet)) else $error("rxwr moved");
   a_rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
      rxrd_access && rxrd_wait |=> rxrd_access && $stable(rxrd_packet)) else $error("rxrd moved");
   a_rr_hold: assert property (@(posedge clk) disable iff (!rst_n)
      rxrr_access && rxrr_wait |=> rxrr_access && $stable(rxrr_packet)) else $error("rxrr moved");

   // Push without pop leaves a word behind, even when dropped on full
   a_mb_flags: assert property (@(posedge clk) disable iff (!rst_n)
      mb_push && !mb_pop |=> mailbox_full || mailbox_not_empty)
      else $error("mailbox flags both low after push");

endmodule

bind erx_core erx_properties #(.ID(ID)) i_props (.*);

// ==== tb/erx_tb.sv ====
`timescale 1ns/1ns
module erx_tb;
   import erx_pkg::*;

   logic          clk;
   logic          rst_n;
   logic          rx_access;
   logic          rx_burst;
   logic          erx_cfg_access;
   logic          rxwr_wait;
   logic          rxrd_wait;
   logic          rxrr_wait;
   emesh_packet_t rx_packet;
   emesh_packet_t erx_cfg_packet;
   logic          rx_rd_wait;
   logic          rx_wr_wait;
   logic          erx_cfg_wait;
   logic          rxwr_access;
   logic          rxrd_access;
   logic          rxrr_access;
   emesh_packet_t rxwr_packet;
   emesh_packet_t rxrd_packet;
   emesh_packet_t rxrr_packet;
   logic [44:0]   idelay_value;
   logic          load_taps;
   logic          mailbox_full;
   logic          mailbox_not_empty;

   integer        seed = 97542;                           // Wait pattern seed
   integer        errors = 0;
   integer        checks = 0;
   integer        cycles = 0;
   integer        limit = 0;                              // Set once records are read
   integer        taps_seen = 0;
   logic [7:0]    kinds [$];
   emesh_packet_t recs [$];
   emesh_packet_t exp_wr [$];
   emesh_packet_t exp_rd [$];
   emesh_packet_t exp_rr [$];

   erx_core #(.ID(12'h999), .MB_DEPTH(4)) i_dut (.*);

   initial clk = 1'b0;
   always #2 clk = ~clk;

   task automatic check(input string name, input logic [103:0] got, input logic [103:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   // One clock, then new random output waits
   task automatic tick();
      @(posedge clk);
      #1;
      if (rst_n) begin
         rxwr_wait = ($random(seed) & 3) == 0;
         rxrd_wait = ($random(seed) & 3) == 0;
         rxrr_wait = ($random(seed) & 3) == 0;
      end
   endtask

   task automatic send_link(input emesh_packet_t pkt);
      tick();
      while (rxwr_wait || rxrd_wait || rxrr_wait) tick();  // Link held off by any wait
      rx_access = 1'b1;
      rx_packet = pkt;
      tick();
      rx_access = 1'b0;
   endtask

   task automatic drain();
      while (exp_wr.size() + exp_rd.size() + exp_rr.size() != 0) tick();
      tick();
      tick();
   endtask

   task automatic send_cfg(input emesh_packet_t pkt);
      drain();                                            // Keeps rxrr order fixed
      while (erx_cfg_wait) tick();
      erx_cfg_access = 1'b1;
      erx_cfg_packet = pkt;
      tick();
      erx_cfg_access = 1'b0;
   endtask

   // Transfer happens at the next rising edge when wait is low
   always @(negedge clk) begin
      if (rst_n && load_taps) taps_seen++;
      if (rst_n) begin                                    // Link waits follow any port wait
         check("rx_wr_wait", 104'(rx_wr_wait), 104'(rxwr_wait | rxrd_wait | rxrr_wait));
         check("rx_rd_wait", 104'(rx_rd_wait), 104'(rxwr_wait | rxrd_wait | rxrr_wait));
      end
      if (rxwr_access && !rxwr_wait) begin
         if (exp_wr.size() == 0) begin
            errors++;
            $display("Unexpected packet on rxwr at %0t ns: %h", $time, rxwr_packet);
         end else check("rxwr_packet", rxwr_packet, exp_wr.pop_front());
      end
      if (rxrd_access && !rxrd_wait) begin
         if (exp_rd.size() == 0) begin
            errors++;
            $display("Unexpected packet on rxrd at %0t ns: %h", $time, rxrd_packet);
         end else check("rxrd_packet", rxrd_packet, exp_rd.pop_front());
      end
      if (rxrr_access && !rxrr_wait) begin
         if (exp_rr.size() == 0) begin
            errors++;
            $display("Unexpected packet on rxrr at %0t ns: %h", $time, rxrr_packet);
         end else check("rxrr_packet", rxrr_packet, exp_rr.pop_front());
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (limit > 0 && cycles > limit) begin
         $display("Timeout after %0d cycles, expected packets never arrived", cycles);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   initial begin
      integer        fd;
      integer        n;
      string         line;
      logic [7:0]    k;
      logic [31:0]   w, dm, cm, dst, dat, src;
      emesh_packet_t pkt;
      {rst_n, rx_access, rx_burst, erx_cfg_access} = '0;
      {rxwr_wait, rxrd_wait, rxrr_wait} = '0;
      rx_packet      = '0;
      erx_cfg_packet = '0;
      fd = $fopen("tb/erx_testdata.txt", "r");
      if (fd == 0) begin
         $display("Could not open tb/erx_testdata.txt");
         $display("*** TEST FAILED ***");
         $finish;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 1 && line[0] != "#") begin
               n = $sscanf(line, "%c %h %h %h %h %h %h", k, w, dm, cm, dst, dat, src);
               if (n == 7) begin
                  kinds.push_back(k);
                  pkt = '{w[0], dm[1:0], cm[4:0], dst, dat, src};
                  recs.push_back(pkt);
               end
            end
         end
         $fclose(fd);
         limit = kinds.size() * 20;
         repeat (8) @(posedge clk);                       // Reset for 8 cycles
         #1 rst_n = 1'b1;
         foreach (kinds[i]) begin
            pkt = recs[i];
            case (kinds[i])
               "L": send_link(pkt);
               "C": send_cfg(pkt);
               "W": exp_wr.push_back(pkt);
               "R": exp_rd.push_back(pkt);
               "S": exp_rr.push_back(pkt);
               "T": begin
                  drain();
                  check("load_taps pulses", 104'(taps_seen), 104'(pkt.dstaddr));
                  check("idelay_value", 104'(idelay_value),
                        104'({pkt.srcaddr[12:0], pkt.data}));
               end
               "F": begin
                  drain();
                  check("mailbox flags", 104'({mailbox_full, mailbox_not_empty}),
                        104'(pkt.data[1:0]));
               end
               default: begin
                  errors++;
                  $display("Unknown record kind in test data, record %0d", i);
               end
            endcase
         end
         drain();
         $display("Checks: %0d  errors: %0d", checks, errors);
         if (errors == 0) begin
            $display("*** TEST PASSED ***");
         end else begin
            $display("*** TEST FAILED ***");
         end
         $finish;
      end
   end

endmodule

// ==== erx.f ====
src/erx_pkg.sv
src/erx_protocol.sv
src/erx_remap.sv
src/erx_cfg.sv
src/erx_mailbox.sv
src/erx_arbiter.sv
src/erx_core.sv
tb/erx_properties.sv
tb/erx_tb.sv

// ==== run_erx.sh ====
#!/bin/sh
# Build and run the erx testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module erx_tb -f erx.f -o erx_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/erx_sim > erx_sim.log 2>&1
status=$?
cat erx_sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qF "*** TEST FAILED ***" erx_sim.log; then
   exit 1
fi
exit 0

// ==== tb/erx_testdata.txt ====
# kind write datamode ctrlmode dstaddr data srcaddr, hex; L link C cfg W/R/S expect rxwr/rxrd/rxrr
# T: dstaddr = load_taps pulses, data/srcaddr = idelay lo/hi; F: data = {full, not_empty}
L 1 0 0 12340010 aaaa0001 0
W 1 0 0 12340010 aaaa0001 0
L 0 1 3 12340020 0 999e0100
R 0 1 3 12340020 0 999e0100
C 1 0 0 999f0000 1 0
C 1 0 0 999f0004 f00 0
C 1 0 0 999f0008 a00 0
L 1 2 5 12340030 bbbb0002 0
W 1 2 5 a2340030 bbbb0002 0
L 0 0 0 56780040 0 999e0200
R 0 0 0 a6780040 0 999e0200
L 1 0 0 999e0040 cccc0003 0
S 1 0 0 999e0040 cccc0003 0
C 0 0 0 999f0004 0 11110000
S 1 0 0 11110000 f00 999f0004
C 0 0 0 999f0008 0 11110004
S 1 0 0 11110004 a00 999f0008
C 1 0 0 999f000c 12345678 0
C 1 0 0 999f0010 1abc 0
T 0 0 0 1 12345678 1abc
C 1 0 0 999f0000 0 0
L 1 0 0 999f0014 d0000001 0
W 1 0 0 999f0014 d0000001 0
L 1 0 0 999f0014 d0000002 0
W 1 0 0 999f0014 d0000002 0
F 0 0 0 0 1 0
L 1 0 0 999f0014 d0000003 0
W 1 0 0 999f0014 d0000003 0
L 1 0 0 999f0014 d0000004 0
W 1 0 0 999f0014 d0000004 0
F 0 0 0 0 3 0
C 0 0 0 999f0014 0 22220000
S 1 0 0 22220000 d0000001 999f0014
C 0 0 0 999f0014 0 22220000
S 1 0 0 22220000 d0000002 999f0014
C 0 0 0 999f0014 0 22220000
S 1 0 0 22220000 d0000003 999f0014
C 0 0 0 999f0014 0 22220000
S 1 0 0 22220000 d0000004 999f0014
F 0 0 0 0 0 0
C 0 0 0 999f0014 0 22220000
S 1 0 0 22220000 0 999f0014
